// ==== video_cfg.svh ====
`ifndef VIDEO_CFG_SVH
`define VIDEO_CFG_SVH

// Horizontal raster in pixels
`define H_TOTAL     80
`define H_ACTIVE    64
`define HS_START    68
`define HS_END      72

// Vertical raster in lines
`define V_TOTAL     40
`define V_ACTIVE    32
`define VS_START    34
`define VS_END      36

// Tile map of 8x8 tiles, 128x128 pixel plane
`define MAP_COLS    16
`define MAP_ROWS    16
`define FETCH_TILES 9

// Pixel clock steps from hdump to the RGB outputs
`define PIPE_DEPTH  2

`endif

// ==== video_timing_pkg.sv ====
`default_nettype none

package video_timing_pkg;

    // Pixel and line counters
    typedef logic [8:0] hcnt_t;
    typedef logic [8:0] vcnt_t;

    // Sync and blanking, all active high
    typedef struct packed {
        logic hs;
        logic vs;
        logic hb;
        logic vb;
    } sync_t;

endpackage

`default_nettype wire

// ==== video_regs_pkg.sv ====
`default_nettype none

package video_regs_pkg;

    typedef logic [15:0] vram_addr_t;
    typedef logic [11:0] rom_addr_t;
    // 4 bits per component, red in the top nibble
    typedef logic [11:0] color_t;
    // Palette bank in 7:4, colour in 3:0
    typedef logic [7:0]  pxl_t;

    typedef struct packed {
        logic        cs;
        logic [3:0]  addr;
        logic [1:0]  dsn;
        logic [15:0] dout;
    } cpu_bus_t;

    typedef struct packed {
        logic [6:0] hpos;
        logic [6:0] vpos;
        vram_addr_t vram_base;
        logic       layer_en;
        color_t     bg_color;
    } video_regs_t;

    typedef struct packed {
        logic       we;
        logic [7:0] addr;
        color_t     data;
    } pal_wr_t;

endpackage

`default_nettype wire

// ==== video_timing.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "video_cfg.svh"

module video_timing
    import video_timing_pkg::*;
(
    input  wire   clk,
    input  wire   rst_n,
    input  wire   pxl_cen,
    output hcnt_t hdump,
    output vcnt_t vdump,
    output vcnt_t vrender,
    output logic  line_start,
    output logic  frame,
    output sync_t sync
);

    logic  h_wrap, v_wrap;
    hcnt_t h_next;
    vcnt_t v_next;

    assign h_wrap = hdump == hcnt_t'(`H_TOTAL - 1);
    assign v_wrap = vdump == vcnt_t'(`V_TOTAL - 1);
    assign h_next = h_wrap ? '0 : hdump + 1'b1;
    assign v_next = v_wrap ? '0 : vdump + 1'b1;

    // Sync and blanking follow the new counter values
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hdump      <= '0;
            vdump      <= '0;
            vrender    <= vcnt_t'(1);
            line_start <= 1'b0;
            frame      <= 1'b0;
            sync       <= '0;
        end else begin
            line_start <= 1'b0;
            if (pxl_cen) begin
                hdump      <= h_next;
                sync.hb    <= h_next >= hcnt_t'(`H_ACTIVE);
                sync.hs    <= h_next >= hcnt_t'(`HS_START) && h_next < hcnt_t'(`HS_END);
                line_start <= h_wrap;
                if (h_wrap) begin
                    vdump   <= v_next;
                    vrender <= (v_next == vcnt_t'(`V_TOTAL - 1)) ? '0 : v_next + 1'b1;
                    sync.vb <= v_next >= vcnt_t'(`V_ACTIVE);
                    sync.vs <= v_next >= vcnt_t'(`VS_START) && v_next < vcnt_t'(`VS_END);
                    if (v_wrap) begin
                        frame <= ~frame;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== video_mmr.sv ====
`timescale 1ns/1ps
`default_nettype none

module video_mmr
    import video_regs_pkg::*;
(
    input  wire         clk,
    input  wire         rst_n,
    input  wire         cpu_bus_t cpu,
    output logic [15:0] mmr_dout,
    output video_regs_t regs,
    output pal_wr_t     pal_wr
);

    localparam logic [3:0] A_HPOS     = 4'd0;
    localparam logic [3:0] A_VPOS     = 4'd1;
    localparam logic [3:0] A_BASE     = 4'd2;
    localparam logic [3:0] A_ENABLE   = 4'd3;
    localparam logic [3:0] A_BGCOLOR  = 4'd4;
    localparam logic [3:0] A_PAL_PTR  = 4'd5;
    localparam logic [3:0] A_PAL_DATA = 4'd6;

    logic [7:0]  pal_ptr;
    logic        wr;
    logic [15:0] merged;

    always_comb begin
        case (cpu.addr)
            A_HPOS:    mmr_dout = {9'd0, regs.hpos};
            A_VPOS:    mmr_dout = {9'd0, regs.vpos};
            A_BASE:    mmr_dout = regs.vram_base;
            A_ENABLE:  mmr_dout = {15'd0, regs.layer_en};
            A_BGCOLOR: mmr_dout = {4'd0, regs.bg_color};
            A_PAL_PTR: mmr_dout = {8'd0, pal_ptr};
            default:   mmr_dout = '0;
        endcase
    end

    // Disabled byte lanes keep the current register contents
    assign wr     = cpu.cs && (cpu.dsn != 2'b11);
    assign merged = {cpu.dsn[1] ? mmr_dout[15:8] : cpu.dout[15:8],
                     cpu.dsn[0] ? mmr_dout[7:0]  : cpu.dout[7:0]};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            regs    <= '0;
            pal_ptr <= '0;
            pal_wr  <= '0;
        end else begin
            pal_wr.we <= 1'b0;
            if (wr) begin
                case (cpu.addr)
                    A_HPOS:    regs.hpos      <= merged[6:0];
                    A_VPOS:    regs.vpos      <= merged[6:0];
                    A_BASE:    regs.vram_base <= merged;
                    A_ENABLE:  regs.layer_en  <= merged[0];
                    A_BGCOLOR: regs.bg_color  <= merged[11:0];
                    A_PAL_PTR: pal_ptr        <= merged[7:0];
                    A_PAL_DATA: begin
                        // One palette write per access, pointer moves on
                        pal_wr.we   <= 1'b1;
                        pal_wr.addr <= pal_ptr;
                        pal_wr.data <= merged[11:0];
                        pal_ptr     <= pal_ptr + 1'b1;
                    end
                    default: ;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// ==== video_scroll.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "video_cfg.svh"

module video_scroll
    import video_timing_pkg::*;
    import video_regs_pkg::*;
(
    input  wire         clk,
    input  wire         rst_n,
    input  wire         pxl_cen,
    input  wire         line_start,
    input  wire         hcnt_t hdump,
    input  wire         vcnt_t vrender,
    input  wire         video_regs_t regs,
    output vram_addr_t  vram_addr,
    output logic        vram_cs,
    input  wire  [15:0] vram_data,
    input  wire         vram_ok,
    output rom_addr_t   rom_addr,
    output logic        rom_cs,
    input  wire  [31:0] rom_data,
    input  wire         rom_ok,
    output pxl_t        pxl
);

    typedef enum logic [1:0] {IDLE, MAP, ROW, WRITE} fetch_st_t;

    fetch_st_t  st;
    logic       front;
    logic [3:0] tile_cnt;
    logic [6:0] hpos_l;
    logic [6:0] ypos_l;
    vram_addr_t base_l;
    logic [3:0] map_col, map_row;
    vram_addr_t map_addr;
    logic [3:0] pal_bank;
    logic [31:0] row_data;
    logic [6:0] rd_pos;
    logic [63:0] rd_word;

    // Each word holds one tile row of eight pixels, two banks of 16 words
    logic [63:0] line_buf [0:31];

    function automatic logic [63:0] pack_row(input logic [31:0] row, input logic [3:0] bank);
        logic [63:0] w;
        for (int k = 0; k < 8; k++) begin
            w[k*8 +: 8] = {bank, row[28-4*k +: 4]};
        end
        return w;
    endfunction

    // Map position wraps on both axes of the 128x128 plane
    assign map_col  = 4'((hpos_l[6:3] + tile_cnt) % `MAP_COLS);
    assign map_row  = 4'(ypos_l[6:3] % `MAP_ROWS);
    assign map_addr = base_l + vram_addr_t'(map_row) * `MAP_COLS + vram_addr_t'(map_col);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            st       <= IDLE;
            front    <= 1'b0;
            tile_cnt <= '0;
            hpos_l   <= '0;
            ypos_l   <= '0;
            base_l   <= '0;
            vram_cs  <= 1'b0;
            rom_cs   <= 1'b0;
        end else if (line_start) begin
            st       <= MAP;
            front    <= ~front;
            tile_cnt <= '0;
            hpos_l   <= regs.hpos;
            ypos_l   <= vrender[6:0] + regs.vpos;
            base_l   <= regs.vram_base;
            vram_cs  <= 1'b0;
            rom_cs   <= 1'b0;
        end else begin
            case (st)
                MAP: begin
                    if (!vram_cs) begin
                        vram_cs <= 1'b1;
                    end else if (vram_ok) begin
                        vram_cs <= 1'b0;
                        rom_cs  <= 1'b1;
                        st      <= ROW;
                    end
                end
                ROW: begin
                    if (rom_ok) begin
                        rom_cs <= 1'b0;
                        st     <= WRITE;
                    end
                end
                WRITE: begin
                    tile_cnt <= tile_cnt + 1'b1;
                    st <= (tile_cnt == 4'(`FETCH_TILES - 1)) ? IDLE : MAP;
                end
                default: ;
            endcase
        end
    end

    // Addresses are set together with the rising cs
    always_ff @(posedge clk) begin
        if (st == MAP && !vram_cs) begin
            vram_addr <= map_addr;
        end
        if (vram_cs && vram_ok) begin
            pal_bank <= vram_data[11:8];
            rom_addr <= {1'b0, vram_data[7:0], ypos_l[2:0]};
        end
        if (rom_cs && rom_ok) begin
            row_data <= rom_data;
        end
        if (st == WRITE) begin
            line_buf[{~front, tile_cnt}] <= pack_row(row_data, pal_bank);
        end
    end

    // Front buffer readout with fine scroll
    assign rd_pos  = hdump[6:0] + {4'd0, hpos_l[2:0]};
    assign rd_word = line_buf[{front, rd_pos[6:3]}];

    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            pxl <= rd_word[rd_pos[2:0]*8 +: 8];
        end
    end

endmodule

`default_nettype wire

// ==== video_colmix.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "video_cfg.svh"

module video_colmix
    import video_timing_pkg::*;
    import video_regs_pkg::*;
(
    input  wire        clk,
    input  wire        rst_n,
    input  wire        pxl_cen,
    input  wire        sync_t sync,
    input  wire        layer_en,
    input  wire [11:0] bg_color,
    input  wire        pal_wr_t pal_wr,
    input  wire        pxl_t pxl,
    output logic [7:0] red,
    output logic [7:0] green,
    output logic [7:0] blue,
    output logic       LHBL_dly,
    output logic       LVBL_dly
);

    color_t pal_ram [0:255];
    color_t col;
    logic   visible;
    logic [`PIPE_DEPTH-1:0] lhbl_sr, lvbl_sr;

    always_ff @(posedge clk) begin
        if (pal_wr.we) begin
            pal_ram[pal_wr.addr] <= pal_wr.data;
        end
    end

    // Colour 0 is transparent
    assign col = (!layer_en || pxl[3:0] == 4'd0) ? bg_color : pal_ram[pxl];

    // Blanking follows the pixel down the pipeline
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lhbl_sr <= '0;
            lvbl_sr <= '0;
        end else if (pxl_cen) begin
            lhbl_sr <= {lhbl_sr[`PIPE_DEPTH-2:0], ~sync.hb};
            lvbl_sr <= {lvbl_sr[`PIPE_DEPTH-2:0], ~sync.vb};
        end
    end

    // Blanking state of the pixel now in pxl
    assign visible = lhbl_sr[`PIPE_DEPTH-2] & lvbl_sr[`PIPE_DEPTH-2];

    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            red   <= visible ? {2{col[11:8]}} : 8'd0;
            green <= visible ? {2{col[7:4]}}  : 8'd0;
            blue  <= visible ? {2{col[3:0]}}  : 8'd0;
        end
    end

    assign LHBL_dly = lhbl_sr[`PIPE_DEPTH-1];
    assign LVBL_dly = lvbl_sr[`PIPE_DEPTH-1];

endmodule

`default_nettype wire

// ==== video_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module video_top
    import video_timing_pkg::*;
    import video_regs_pkg::*;
(
    input  wire        clk,
    input  wire        rst_n,
    input  wire        pxl_cen,
    // CPU
    input  wire        cpu_bus_t cpu,
    output wire [15:0] mmr_dout,
    // Video RAM
    output vram_addr_t vram_addr,
    output wire        vram_cs,
    input  wire [15:0] vram_data,
    input  wire        vram_ok,
    // Graphics ROM
    output rom_addr_t  rom_addr,
    output wire        rom_cs,
    input  wire [31:0] rom_data,
    input  wire        rom_ok,
    // Video out
    output wire        HS,
    output wire        VS,
    output wire        HB,
    output wire        VB,
    output wire        LHBL_dly,
    output wire        LVBL_dly,
    output wire [7:0]  red,
    output wire [7:0]  green,
    output wire [7:0]  blue,
    output hcnt_t      hdump,
    output vcnt_t      vdump,
    output wire        frame
);

    vcnt_t       vrender;
    logic        line_start;
    sync_t       sync;
    video_regs_t regs;
    pal_wr_t     pal_wr;
    pxl_t        pxl;

    assign HS = sync.hs;
    assign VS = sync.vs;
    assign HB = sync.hb;
    assign VB = sync.vb;

    video_timing u_timing (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .pxl_cen    ( pxl_cen    ),
        .hdump      ( hdump      ),
        .vdump      ( vdump      ),
        .vrender    ( vrender    ),
        .line_start ( line_start ),
        .frame      ( frame      ),
        .sync       ( sync       )
    );

    video_mmr u_mmr (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .cpu      ( cpu      ),
        .mmr_dout ( mmr_dout ),
        .regs     ( regs     ),
        .pal_wr   ( pal_wr   )
    );

    video_scroll u_scroll (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .pxl_cen    ( pxl_cen    ),
        .line_start ( line_start ),
        .hdump      ( hdump      ),
        .vrender    ( vrender    ),
        .regs       ( regs       ),
        .vram_addr  ( vram_addr  ),
        .vram_cs    ( vram_cs    ),
        .vram_data  ( vram_data  ),
        .vram_ok    ( vram_ok    ),
        .rom_addr   ( rom_addr   ),
        .rom_cs     ( rom_cs     ),
        .rom_data   ( rom_data   ),
        .rom_ok     ( rom_ok     ),
        .pxl        ( pxl        )
    );

    video_colmix u_colmix (
        .clk      ( clk           ),
        .rst_n    ( rst_n         ),
        .pxl_cen  ( pxl_cen       ),
        .sync     ( sync          ),
        .layer_en ( regs.layer_en ),
        .bg_color ( regs.bg_color ),
        .pal_wr   ( pal_wr        ),
        .pxl      ( pxl           ),
        .red      ( red           ),
        .green    ( green         ),
        .blue     ( blue          ),
        .LHBL_dly ( LHBL_dly      ),
        .LVBL_dly ( LVBL_dly      )
    );

endmodule

`default_nettype wire

// ==== tb_video_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_video_mem
    import video_regs_pkg::*;
#(
    parameter int SEED = 46367
) (
    input  wire         clk,
    input  wire         rst_n,
    input  wire         vram_addr_t vram_addr,
    input  wire         vram_cs,
    output logic [15:0] vram_data,
    output logic        vram_ok,
    input  wire         rom_addr_t rom_addr,
    input  wire         rom_cs,
    output logic [31:0] rom_data,
    output logic        rom_ok
);

    integer seed;
    integer vwait;
    integer rwait;
    integer draw;

    // Full VRAM word space and one 32-bit row per ROM address
    logic [15:0] vram [0:65535];
    logic [31:0] rom  [0:4095];

    initial begin
        seed = SEED;
        vram_ok   <= 1'b0;
        rom_ok    <= 1'b0;
        vram_data <= '0;
        rom_data  <= '0;
        vwait     <= -1;
        rwait     <= -1;
        for (int a = 0; a < 65536; a++) begin
            vram[a] = 16'($random(seed));
        end
        for (int a = 0; a < 4096; a++) begin
            rom[a] = $random(seed);
        end
    end

    // ok follows a request after 1 to 4 cycles with the data
    always @(posedge clk) begin
        if (!rst_n) begin
            vram_ok   <= 1'b0;
            rom_ok    <= 1'b0;
            vram_data <= '0;
            rom_data  <= '0;
            vwait     <= -1;
            rwait     <= -1;
        end else begin
            vram_ok <= 1'b0;
            rom_ok  <= 1'b0;
            if (vram_cs && !vram_ok) begin
                if (vwait < 0) begin
                    draw = $random(seed) & 3;
                    if (draw == 0) begin
                        vram_ok   <= 1'b1;
                        vram_data <= vram[vram_addr];
                    end else begin
                        vwait <= draw - 1;
                    end
                end else if (vwait == 0) begin
                    vram_ok   <= 1'b1;
                    vram_data <= vram[vram_addr];
                    vwait     <= -1;
                end else begin
                    vwait <= vwait - 1;
                end
            end
            if (rom_cs && !rom_ok) begin
                if (rwait < 0) begin
                    draw = $random(seed) & 3;
                    if (draw == 0) begin
                        rom_ok   <= 1'b1;
                        rom_data <= rom[rom_addr];
                    end else begin
                        rwait <= draw - 1;
                    end
                end else if (rwait == 0) begin
                    rom_ok   <= 1'b1;
                    rom_data <= rom[rom_addr];
                    rwait    <= -1;
                end else begin
                    rwait <= rwait - 1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== tb_video.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "video_cfg.svh"

module tb_video
    import video_timing_pkg::*;
    import video_regs_pkg::*;
();

    localparam int FRAME_CLKS   = 2 * `H_TOTAL * `V_TOTAL;
    // Raster frame, image frames with their vblank waits
    localparam int TEST_FRAMES  = 12;
    localparam int TIMEOUT_CLKS = (TEST_FRAMES + 4) * FRAME_CLKS;

    logic        clk;
    logic        rst_n;
    logic        pxl_cen;
    cpu_bus_t    cpu;
    logic [15:0] mmr_dout;
    vram_addr_t  vram_addr;
    logic        vram_cs;
    logic [15:0] vram_data;
    logic        vram_ok;
    rom_addr_t   rom_addr;
    logic        rom_cs;
    logic [31:0] rom_data;
    logic        rom_ok;
    logic        HS;
    logic        VS;
    logic        HB;
    logic        VB;
    logic        LHBL_dly;
    logic        LVBL_dly;
    logic [7:0]  red;
    logic [7:0]  green;
    logic [7:0]  blue;
    hcnt_t       hdump;
    vcnt_t       vdump;
    logic        frame;

    integer      seed;
    int          err_cnt;
    int          check_cnt;
    int          cycles;
    int          trans_seen;
    logic [15:0] reg_model [0:6];
    logic [11:0] pal_model [0:255];

    video_top video_top_inst (
        .clk       ( clk       ),
        .rst_n     ( rst_n     ),
        .pxl_cen   ( pxl_cen   ),
        .cpu       ( cpu       ),
        .mmr_dout  ( mmr_dout  ),
        .vram_addr ( vram_addr ),
        .vram_cs   ( vram_cs   ),
        .vram_data ( vram_data ),
        .vram_ok   ( vram_ok   ),
        .rom_addr  ( rom_addr  ),
        .rom_cs    ( rom_cs    ),
        .rom_data  ( rom_data  ),
        .rom_ok    ( rom_ok    ),
        .HS        ( HS        ),
        .VS        ( VS        ),
        .HB        ( HB        ),
        .VB        ( VB        ),
        .LHBL_dly  ( LHBL_dly  ),
        .LVBL_dly  ( LVBL_dly  ),
        .red       ( red       ),
        .green     ( green     ),
        .blue      ( blue      ),
        .hdump     ( hdump     ),
        .vdump     ( vdump     ),
        .frame     ( frame     )
    );

    tb_video_mem #(.SEED(46367)) mem_inst (
        .clk       ( clk       ),
        .rst_n     ( rst_n     ),
        .vram_addr ( vram_addr ),
        .vram_cs   ( vram_cs   ),
        .vram_data ( vram_data ),
        .vram_ok   ( vram_ok   ),
        .rom_addr  ( rom_addr  ),
        .rom_cs    ( rom_cs    ),
        .rom_data  ( rom_data  ),
        .rom_ok    ( rom_ok    )
    );

    always #20 clk = ~clk;

    // Pixel enable on every second clock
    always @(posedge clk) begin
        pxl_cen <= ~pxl_cen;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CLKS) begin
            $display("timeout: test sequence still running after %0d clock cycles", cycles);
            $display("Errors found");
            $finish;
        end
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("error at time %0t: %s is %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic end_test(input string name, input int mismatches);
        $display("test %-22s %0d mismatches", name, mismatches);
    endtask

    // Valid bits of each register, palette data reads as zero
    function automatic logic [15:0] reg_mask(input logic [3:0] a);
        case (a)
            4'd0, 4'd1: return 16'h007f;
            4'd2:       return 16'hffff;
            4'd3:       return 16'h0001;
            4'd4:       return 16'h0fff;
            4'd5:       return 16'h00ff;
            default:    return 16'h0000;
        endcase
    endfunction

    task automatic cpu_write(input logic [3:0] a, input logic [15:0] d, input logic [1:0] dsn);
        logic [15:0] old;
        logic [15:0] merged;
        old = (a == 4'd6) ? 16'd0 : reg_model[a];
        merged[15:8] = dsn[1] ? old[15:8] : d[15:8];
        merged[7:0]  = dsn[0] ? old[7:0] : d[7:0];
        @(posedge clk);
        cpu.cs   <= 1'b1;
        cpu.addr <= a;
        cpu.dsn  <= dsn;
        cpu.dout <= d;
        @(posedge clk);
        cpu.cs   <= 1'b0;
        cpu.dsn  <= 2'b11;
        if (a == 4'd6) begin
            pal_model[reg_model[5][7:0]] = merged[11:0];
            reg_model[5] = {8'd0, reg_model[5][7:0] + 8'd1};
        end else if (a < 4'd6) begin
            reg_model[a] = merged & reg_mask(a);
        end
    endtask

    task automatic cpu_read(input logic [3:0] a, output logic [15:0] d);
        @(posedge clk);
        cpu.addr <= a;
        @(posedge clk);
        d = mmr_dout;
    endtask

    // Reference pixel from the map, ROM and palette rules
    task automatic model_pixel(input int x, input int y, output logic [23:0] rgb,
                               output logic clear);
        logic [6:0]  mx;
        logic [6:0]  my;
        logic [15:0] word;
        logic [11:0] ra;
        logic [31:0] row;
        logic [3:0]  nib;
        logic [11:0] c;
        mx   = 7'(x) + reg_model[0][6:0];
        my   = 7'(y) + reg_model[1][6:0];
        word = mem_inst.vram[reg_model[2] + 16'(my[6:3]) * 16'(`MAP_COLS) + 16'(mx[6:3])];
        ra   = 12'(word[7:0]) * 12'd8 + 12'(my[2:0]);
        row  = mem_inst.rom[ra];
        // Leftmost pixel sits in the top nibble
        nib   = 4'(row >> (5'd28 - 5'(mx[2:0]) * 5'd4));
        clear = (nib == 4'd0);
        if (!reg_model[3][0] || clear) begin
            c = reg_model[4][11:0];
        end else begin
            c = pal_model[{word[11:8], nib}];
        end
        rgb = {{2{c[11:8]}}, {2{c[7:4]}}, {2{c[3:0]}}};
    endtask

    task automatic next_pixel();
        @(posedge clk);
        while (!pxl_cen) begin
            @(posedge clk);
        end
    endtask

    task automatic wait_vblank();
        next_pixel();
        while (!LVBL_dly) begin
            next_pixel();
        end
        while (LVBL_dly) begin
            next_pixel();
        end
    endtask

    // One full frame from the first visible pixel to the next frame's first
    task automatic grab_frame(input bit check_pixels);
        int          col;
        int          row;
        int          hs_line;
        int          vs_cnt;
        int          frame_cnt;
        logic        hs_prev;
        logic        vs_prev;
        logic        frame_prev;
        logic        seen_blank;
        logic        clear;
        logic [23:0] exp_rgb;
        col = 0;
        row = 0;
        hs_line = 0;
        vs_cnt = 0;
        frame_cnt = 0;
        trans_seen = 0;
        seen_blank = 1'b0;
        next_pixel();
        while (LVBL_dly) begin
            next_pixel();
        end
        while (!LVBL_dly) begin
            next_pixel();
        end
        hs_prev = HS;
        vs_prev = VS;
        frame_prev = frame;
        while (!(seen_blank && LVBL_dly)) begin
            if (LHBL_dly && LVBL_dly) begin
                if (check_pixels) begin
                    model_pixel(col, row, exp_rgb, clear);
                    check($sformatf("rgb at x=%0d y=%0d", col, row),
                          {8'd0, red, green, blue}, {8'd0, exp_rgb});
                    if (clear) begin
                        trans_seen++;
                    end
                end
                col++;
            end else if (col != 0) begin
                check("visible pixels per line", 32'(col), 32'(`H_ACTIVE));
                row++;
                col = 0;
            end
            if (!LVBL_dly) begin
                seen_blank = 1'b1;
            end
            if (HS && !hs_prev) begin
                hs_line++;
            end
            if (VS && !vs_prev) begin
                vs_cnt++;
            end
            if (hdump == '0) begin
                check("HS pulses per line", 32'(hs_line), 32'd1);
                hs_line = 0;
            end
            // Blanking covers everything outside the active area
            check("HB", 32'(HB), 32'(hdump >= hcnt_t'(`H_ACTIVE)));
            check("VB", 32'(VB), 32'(vdump >= vcnt_t'(`V_ACTIVE)));
            if (frame != frame_prev) begin
                frame_cnt++;
                check("vdump at frame toggle", 32'(vdump), 32'd0);
            end
            hs_prev = HS;
            vs_prev = VS;
            frame_prev = frame;
            next_pixel();
        end
        check("visible lines per frame", 32'(row), 32'(`V_ACTIVE));
        check("VS pulses per frame", 32'(vs_cnt), 32'd1);
        check("frame toggles per frame", 32'(frame_cnt), 32'd1);
    endtask

    initial begin
        logic [15:0] d;
        logic [1:0]  dsn;
        logic [15:0] got;
        logic [6:0]  hpos;
        logic [6:0]  vpos;
        int          errs;
        int          timing_errs;
        int          reset_errs;
        int          image_errs;
        clk        = 1'b0;
        rst_n      <= 1'b0;
        pxl_cen    <= 1'b0;
        cpu        <= '0;
        cpu.dsn    <= 2'b11;
        seed       = 46367;
        err_cnt    = 0;
        check_cnt  = 0;
        cycles     <= 0;
        trans_seen = 0;
        image_errs = 0;
        for (int i = 0; i < 7; i++) begin
            reg_model[i] = '0;
        end
        for (int i = 0; i < 256; i++) begin
            pal_model[i] = '0;
        end
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        errs = err_cnt;
        check("hdump", 32'(hdump), 32'd0);
        check("vdump", 32'(vdump), 32'd0);
        check("frame", 32'(frame), 32'd0);
        check("HS", 32'(HS), 32'd0);
        check("VS", 32'(VS), 32'd0);
        timing_errs = err_cnt - errs;
        errs = err_cnt;
        check("vram_cs", 32'(vram_cs), 32'd0);
        check("rom_cs", 32'(rom_cs), 32'd0);
        reset_errs = err_cnt - errs;

        // Round 0 writes all lanes so every register starts known
        errs = err_cnt;
        for (int round = 0; round < 8; round++) begin
            for (int a = 0; a < 7; a++) begin
                d = 16'($random(seed));
                dsn = (round == 0) ? 2'b00 : 2'($random(seed));
                if (dsn == 2'b11) begin
                    dsn = 2'b00;
                end
                cpu_write(4'(a), d, dsn);
                cpu_read(4'(a), got);
                check($sformatf("mmr_dout reg %0d", a), 32'(got), 32'(reg_model[a]));
            end
        end
        end_test("register readback", err_cnt - errs);

        errs = err_cnt;
        grab_frame(1'b0);
        end_test("raster timing", timing_errs + err_cnt - errs);

        errs = err_cnt;
        wait_vblank();
        cpu_write(4'd0, 16'd0, 2'b00);
        cpu_write(4'd1, 16'd0, 2'b00);
        cpu_write(4'd2, 16'($random(seed)), 2'b00);
        cpu_write(4'd3, 16'd1, 2'b00);
        cpu_write(4'd4, 16'($random(seed)), 2'b00);
        cpu_write(4'd5, 16'd0, 2'b00);
        for (int i = 0; i < 256; i++) begin
            cpu_write(4'd6, 16'($random(seed)), 2'b00);
        end
        grab_frame(1'b1);
        image_errs += err_cnt - errs;
        end_test("unscrolled image", err_cnt - errs);

        // Large offsets force wrapping on both map axes
        errs = err_cnt;
        wait_vblank();
        hpos = 7'($random(seed));
        hpos[6] = 1'b1;
        if (hpos[2:0] == 3'd0) begin
            hpos[0] = 1'b1;
        end
        vpos = 7'($random(seed));
        vpos[6:5] = 2'b11;
        if (vpos[2:0] == 3'd0) begin
            vpos[0] = 1'b1;
        end
        cpu_write(4'd0, {9'd0, hpos}, 2'b00);
        cpu_write(4'd1, {9'd0, vpos}, 2'b00);
        cpu_write(4'd2, 16'($random(seed)), 2'b00);
        grab_frame(1'b1);
        image_errs += err_cnt - errs;
        end_test("scrolled image", err_cnt - errs);

        errs = err_cnt;
        wait_vblank();
        cpu_write(4'd3, 16'd0, 2'b00);
        cpu_write(4'd4, 16'($random(seed)), 2'b00);
        grab_frame(1'b1);
        wait_vblank();
        cpu_write(4'd3, 16'd1, 2'b00);
        cpu_write(4'd4, 16'($random(seed)), 2'b00);
        grab_frame(1'b1);
        check("transparent pixels in frame", 32'(trans_seen != 0), 32'd1);
        image_errs += err_cnt - errs;
        end_test("transparency and enable", err_cnt - errs);

        end_test("memory back-pressure", reset_errs + image_errs);

        $display("summary: 6 tests, %0d checks, %0d errors", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+.
video_timing_pkg.sv
video_regs_pkg.sv
video_timing.sv
video_mmr.sv
video_scroll.sv
video_colmix.sv
video_top.sv
tb_video_mem.sv
tb_video.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the video testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal -f filelist.f --top-module tb_video -o tb_video_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_video_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Errors found" "$LOG"; then
    echo "FAIL"
    exit 1
fi

echo "PASS"
exit 0
